// ==== source/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
  input  mips_pkg::id_ex_t  i_id_ex,
  output mips_pkg::ex_mem_t o_ex_mem
);
  import mips_pkg::*;

  ctrl_t     ctrl;
  alu_ctrl_t alu_ctrl;
  word_t     op_a;
  word_t     op_b;
  word_t     alu_result;
  reg_addr_t write_register;

  assign ctrl = i_id_ex.ctrl;

  // ALU control from operation class and function field
  always_comb begin
    case (ctrl.alu_op)
      alu_add: alu_ctrl = ctl_add;
      alu_sub: alu_ctrl = ctl_sub;
      alu_funct: begin
        case (i_id_ex.funct)
          funct_add: alu_ctrl = ctl_add;
          funct_sub: alu_ctrl = ctl_sub;
          funct_and: alu_ctrl = ctl_and;
          funct_or:  alu_ctrl = ctl_or;
          funct_slt: alu_ctrl = ctl_slt;
          default:   alu_ctrl = ctl_add;
        endcase
      end
      default: alu_ctrl = ctl_add;
    endcase
  end

  assign op_a = i_id_ex.read_data_1;
  assign op_b = ctrl.alu_src ? i_id_ex.imm : i_id_ex.read_data_2;

  always_comb begin
    case (alu_ctrl)
      ctl_and: alu_result = op_a & op_b;
      ctl_or:  alu_result = op_a | op_b;
      ctl_add: alu_result = op_a + op_b;
      ctl_sub: alu_result = op_a - op_b;
      ctl_slt: alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0; // Signed compare
      default: alu_result = op_a + op_b;
    endcase
  end

  assign write_register = ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;

  always_comb begin
    o_ex_mem.alu_result     = alu_result;
    o_ex_mem.store_data     = i_id_ex.read_data_2;
    o_ex_mem.write_register = write_register;
    o_ex_mem.reg_write      = ctrl.reg_write && (write_register != '0); // Drop writes to r0
    o_ex_mem.mem_read       = ctrl.mem_read;
    o_ex_mem.mem_write      = ctrl.mem_write;
    o_ex_mem.mem_to_reg     = ctrl.mem_to_reg;
  end

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
  input  logic              clk,
  input  logic              i_reset,
  input  mips_pkg::if_id_t  i_if_id,
  input  mips_pkg::mem_wb_t i_wb,
  output mips_pkg::id_ex_t  o_id_ex
);
  import mips_pkg::*;

  word_t     instr;
  opcode_t   opcode;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  ctrl_t     ctrl;
  word_t     imm;
  word_t     read_data_1;
  word_t     read_data_2;
  logic      wb_en;

  word_t regs [32];

  assign instr  = i_if_id.instr;
  assign opcode = opcode_t'(instr[31:26]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = {{16{instr[15]}}, instr[15:0]};

  // Main control decoder
  always_comb begin
    ctrl = '0;
    case (opcode)
      op_rtype: begin
        ctrl.alu_op    = alu_funct;
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      op_addi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_add;
        ctrl.reg_write = 1'b1;
      end
      op_lw: begin
        ctrl.alu_src    = 1'b1;
        ctrl.alu_op     = alu_add;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      op_sw: begin
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_add;
        ctrl.mem_write = 1'b1;
      end
      default: ctrl = '0; // Unknown opcode behaves as a no-op
    endcase
  end

  // Register 0 is never written so it stays zero
  assign wb_en = i_wb.reg_write && (i_wb.write_register != '0);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[i_wb.write_register] <= i_wb.write_data;
    end
  end

  // Write-through so a decode in the write-back cycle sees the new value
  assign read_data_1 = (wb_en && (i_wb.write_register == rs)) ? i_wb.write_data
                                                              : regs[rs];
  assign read_data_2 = (wb_en && (i_wb.write_register == rt)) ? i_wb.write_data
                                                              : regs[rt];

  always_comb begin
    o_id_ex.read_data_1 = read_data_1;
    o_id_ex.read_data_2 = read_data_2;
    o_id_ex.imm         = imm;
    o_id_ex.rt          = rt;
    o_id_ex.rd          = rd;
    o_id_ex.funct       = instr[5:0];
    o_id_ex.ctrl        = ctrl;
  end

endmodule

// ==== source/if_stage.sv ====
`timescale 1ns/1ps

module if_stage #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          i_reset,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  mips_pkg::word_t               i_imem_data,
  output mips_pkg::if_id_t              o_if_id
);
  import mips_pkg::*;

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  word_t pc;
  word_t next_pc;
  word_t instr;
  logic  pc_in_range;

  word_t imem [IMEM_DEPTH];

  // Program load port
  always_ff @(posedge clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_data;
    end
  end

  assign next_pc = pc + 32'd4; // No branches, always sequential

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign pc_in_range = (pc[31:2] < IMEM_DEPTH);

  // Past the end of memory the core sees no-ops
  assign instr = pc_in_range ? imem[pc[IMEM_AW+1:2]] : '0;

  assign o_if_id.next_pc = next_pc;
  assign o_if_id.instr   = instr;

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic              clk,
  input  logic              i_reset,
  input  mips_pkg::ex_mem_t i_ex_mem,
  output mips_pkg::mem_wb_t o_mem_wb
);
  import mips_pkg::*;

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  logic [DMEM_AW-1:0] addr;
  logic               addr_ok;
  word_t              load_data;

  word_t dmem [DMEM_DEPTH];

  // Word addressed, byte offset ignored
  assign addr    = i_ex_mem.alu_result[DMEM_AW+1:2];
  assign addr_ok = (i_ex_mem.alu_result[31:2] < DMEM_DEPTH);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (i_ex_mem.mem_write && addr_ok) begin
      dmem[addr] <= i_ex_mem.store_data;
    end
  end

  assign load_data = (i_ex_mem.mem_read && addr_ok) ? dmem[addr] : '0;

  // Write-back data select
  always_comb begin
    o_mem_wb.write_data     = i_ex_mem.mem_to_reg ? load_data : i_ex_mem.alu_result;
    o_mem_wb.write_register = i_ex_mem.write_register;
    o_mem_wb.reg_write      = i_ex_mem.reg_write;
  end

endmodule

// ==== source/mips.sv ====
`timescale 1ns/1ps

module mips #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          i_reset,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  output logic                          o_reg_write,
  output logic [4:0]                    o_write_register,
  output logic [31:0]                   o_result
);
  import mips_pkg::*;

  if_id_t  if_d;   // Fetch output
  if_id_t  id_q;   // Decode input
  id_ex_t  id_d;
  id_ex_t  ex_q;
  ex_mem_t ex_d;
  ex_mem_t mem_q;
  mem_wb_t mem_d;
  mem_wb_t wb_q;   // Register file write and top outputs

  if_stage #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) if_stage_inst (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_imem_we   (i_imem_we),
    .i_imem_addr (i_imem_addr),
    .i_imem_data (i_imem_data),
    .o_if_id     (if_d)
  );

  pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk     (clk),
    .i_reset (i_reset),
    .i_d     (if_d),
    .o_q     (id_q)
  );

  id_stage id_stage_inst (
    .clk     (clk),
    .i_reset (i_reset),
    .i_if_id (id_q),
    .i_wb    (wb_q),    // Write-back feeds the register file
    .o_id_ex (id_d)
  );

  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk     (clk),
    .i_reset (i_reset),
    .i_d     (id_d),
    .o_q     (ex_q)
  );

  ex_stage ex_stage_inst (
    .i_id_ex  (ex_q),
    .o_ex_mem (ex_d)
  );

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk     (clk),
    .i_reset (i_reset),
    .i_d     (ex_d),
    .o_q     (mem_q)
  );

  mem_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) mem_stage_inst (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_ex_mem (mem_q),
    .o_mem_wb (mem_d)
  );

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk     (clk),
    .i_reset (i_reset),
    .i_d     (mem_d),
    .o_q     (wb_q)
  );

  assign o_reg_write      = wb_q.reg_write;
  assign o_write_register = wb_q.write_register;
  assign o_result         = wb_q.write_data;

endmodule

// ==== source/mips_pkg.sv ====
package mips_pkg;

  typedef logic [31:0] word_t;     // Data or instruction word
  typedef logic [4:0]  reg_addr_t; // Register number

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_addi  = 6'h08,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_t;

  // R-type function field, instr[5:0]
  localparam logic [5:0] funct_add = 6'h20;
  localparam logic [5:0] funct_sub = 6'h22;
  localparam logic [5:0] funct_and = 6'h24;
  localparam logic [5:0] funct_or  = 6'h25;
  localparam logic [5:0] funct_slt = 6'h2a;

  // Operation class handed from decode to execute
  typedef enum logic [1:0] {
    alu_add   = 2'b00, // Address calc and addi
    alu_sub   = 2'b01, // Reserved
    alu_funct = 2'b10  // Follow function field
  } alu_op_t;

  // Classic MIPS ALU control encoding
  typedef enum logic [2:0] {
    ctl_and = 3'b000,
    ctl_or  = 3'b001,
    ctl_add = 3'b010,
    ctl_sub = 3'b110,
    ctl_slt = 3'b111
  } alu_ctrl_t;

  typedef struct packed {
    logic    alu_src;    // Immediate as second operand
    alu_op_t alu_op;
    logic    reg_dst;    // Destination is rd
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg; // Write back the loaded word
  } ctrl_t;

  typedef struct packed {
    word_t next_pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    word_t      read_data_1;
    word_t      read_data_2;
    word_t      imm;         // Sign extended
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [5:0] funct;
    ctrl_t      ctrl;
  } id_ex_t;

  typedef struct packed {
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t write_register;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
  } ex_mem_t;

  typedef struct packed {
    word_t     write_data;
    reg_addr_t write_register;
    logic      reg_write;
  } mem_wb_t;

endpackage

// ==== source/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     i_reset,
  input  payload_t i_d,
  output payload_t o_q
);

  // All-zero payload is a bubble, every write enable low
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_q <= '0;
    end else begin
      o_q <= i_d;
    end
  end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

endmodule

// ==== verif/tb_program.svh ====
task automatic fill_tables();
  // prog holds one instruction word per entry with the queue index as word address
  // exp_wb holds fetch word, destination register and value in write-back order

  // Immediates and arithmetic
  prog.push_back(encode_i(op_addi, 5'd1, 5'd0, 16'd5));      // 0 sets r1 to 5
  prog.push_back(encode_i(op_addi, 5'd2, 5'd0, 16'hfffd));   // 1 sets r2 to -3
  prog.push_back(encode_i(op_addi, 5'd3, 5'd0, 16'h1234));   // 2 sets r3 to 0x1234
  prog.push_back(encode_i(op_addi, 5'd4, 5'd1, 16'd10));     // 3 reads r1 by write-through
  prog.push_back(encode_r(5'd5, 5'd1, 5'd2, funct_add));     // 4
  prog.push_back(encode_r(5'd6, 5'd2, 5'd3, funct_sub));     // 5
  prog.push_back(encode_i(op_addi, 5'd7, 5'd0, 16'hffff));   // 6 sets r7 to -1
  // Logic and compare
  prog.push_back(encode_r(5'd8, 5'd2, 5'd4, funct_and));     // 7
  prog.push_back(encode_r(5'd9, 5'd1, 5'd3, funct_or));      // 8 has overlapping bits
  prog.push_back(encode_r(5'd10, 5'd2, 5'd1, funct_slt));    // 9 compares -3 with 5
  prog.push_back(encode_r(5'd11, 5'd1, 5'd2, funct_slt));    // 10
  prog.push_back(encode_r(5'd12, 5'd7, 5'd7, funct_add));    // 11 wraps
  // Memory round trip and dropped writes
  prog.push_back(encode_i(op_sw, 5'd9, 5'd1, 16'd3));        // 12 stores to byte address 8
  prog.push_back(encode_i(op_addi, 5'd0, 5'd0, 16'd7));      // 13
  prog.push_back(encode_r(5'd0, 5'd1, 5'd1, funct_add));     // 14
  prog.push_back(encode_i(op_lw, 5'd13, 5'd0, 16'd8));       // 15
  prog.push_back(encode_i(op_lw, 5'd14, 5'd0, 16'd40));      // 16 loads a word never written
  prog.push_back(encode_r(5'd15, 5'd0, 5'd1, funct_add));    // 17 reads r0 as 0
  prog.push_back(32'h0000_0000);                             // 18
  prog.push_back(encode_r(5'd16, 5'd13, 5'd14, funct_add));  // 19
  prog.push_back(encode_i(op_addi, 5'd17, 5'd7, 16'd2));     // 20
  prog.push_back(encode_r(5'd18, 5'd0, 5'd1, funct_sub));    // 21
  prog.push_back(32'h0000_0000);                             // 22

  expect_write(0, 5'd1, 32'h0000_0005);
  expect_write(1, 5'd2, 32'hffff_fffd);
  expect_write(2, 5'd3, 32'h0000_1234);
  expect_write(3, 5'd4, 32'h0000_000f);
  expect_write(4, 5'd5, 32'h0000_0002);
  expect_write(5, 5'd6, 32'hffff_edc9);  // -3 - 4660
  expect_write(6, 5'd7, 32'hffff_ffff);
  expect_write(7, 5'd8, 32'h0000_000d);
  expect_write(8, 5'd9, 32'h0000_1235);
  expect_write(9, 5'd10, 32'h0000_0001);
  expect_write(10, 5'd11, 32'h0000_0000);
  expect_write(11, 5'd12, 32'hffff_fffe);
  expect_write(15, 5'd13, 32'h0000_1235);
  expect_write(16, 5'd14, 32'h0000_0000);
  expect_write(17, 5'd15, 32'h0000_0005);
  expect_write(19, 5'd16, 32'h0000_1235);
  expect_write(20, 5'd17, 32'h0000_0001);
  expect_write(21, 5'd18, 32'hffff_fffb);
endtask

// ==== verif/tb_mips.sv ====
`timescale 1ns/1ps

module tb_mips;
  import mips_pkg::*;

  localparam int  IMEM_DEPTH   = 64;
  localparam int  DMEM_DEPTH   = 64;
  localparam int  IMEM_AW      = $clog2(IMEM_DEPTH);
  localparam int  RESET_CYCLES = 8;
  localparam int  LATENCY      = 4;  // Fetch to write-back
  localparam int  MARGIN       = 20;
  localparam time DRIVE_DELAY  = 1ns;

  typedef struct packed {
    int        fetch; // Word address of the producer
    reg_addr_t rd;
    word_t     value;
  } wb_entry_t;

  logic               clk;
  logic               reset;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_addr;
  word_t              imem_data;
  logic               reg_write;
  reg_addr_t          write_register;
  word_t              result;

  word_t     prog [$];
  wb_entry_t exp_wb [$];

  int   exp_idx       = 0;
  int   cycle         = 0;  // Edges since reset release
  int   reset_edges   = 0;
  int   timeout_limit = 0;
  int   checked       = 0;
  int   mismatches    = 0;
  int   missing       = 0;
  int   extra         = 0;
  int   other_errors  = 0;
  logic running       = 1'b0;
  logic drained       = 1'b0;

  tb_clock #(.PERIOD_NS(8.0)) u_clock (.o_clk(clk));

  mips #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_dut (
    .clk              (clk),
    .i_reset          (reset),
    .i_imem_we        (imem_we),
    .i_imem_addr      (imem_addr),
    .i_imem_data      (imem_data),
    .o_reg_write      (reg_write),
    .o_write_register (write_register),
    .o_result         (result)
  );

  function automatic word_t encode_r(reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                     logic [5:0] funct);
    return {op_rtype, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic word_t encode_i(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic expect_write(input int fetch, input reg_addr_t rd, input word_t value);
    wb_entry_t e;
    e.fetch = fetch;
    e.rd    = rd;
    e.value = value;
    exp_wb.push_back(e);
  endtask

  `include "tb_program.svh"

  task automatic check_reg(input reg_addr_t actual, input reg_addr_t expected, input int k);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch at %0t: cycle %0d wrote register %0d, expected %0d",
               $time, k, actual, expected);
    end
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input int k);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch at %0t: cycle %0d wrote 0x%08h, expected 0x%08h",
               $time, k, actual, expected);
    end
  endtask

  // One write-back may fall due per cycle at fetch word plus latency
  task automatic check_cycle(input int k);
    bit due;
    due = (exp_idx < exp_wb.size()) && (exp_wb[exp_idx].fetch + LATENCY == k);
    if (reg_write === 1'b1 && due) begin
      check_reg(write_register, exp_wb[exp_idx].rd, k);
      check_word(result, exp_wb[exp_idx].value, k);
      checked++;
      exp_idx++;
    end else if (reg_write === 1'b1) begin
      extra++;
      $display("Error at %0t: unexpected write of register %0d in cycle %0d",
               $time, write_register, k);
    end else begin
      if (reg_write !== 1'b0) begin
        other_errors++;
        $display("Error at %0t: o_reg_write is unknown in cycle %0d", $time, k);
      end
      if (due) begin
        missing++;
        $display("Error at %0t: no write of register %0d from word %0d in cycle %0d",
                 $time, exp_wb[exp_idx].rd, exp_wb[exp_idx].fetch, k);
        exp_idx++;
      end
    end
  endtask

  // Monitor samples the values held since the previous edge
  always @(posedge clk) begin
    if (!running) begin
      reset_edges++;
      if (reset_edges > 1 && reg_write !== 1'b0) begin
        other_errors++;
        $display("Error at %0t: o_reg_write is not low during reset", $time);
      end
    end else begin
      check_cycle(cycle);
      cycle++;
      if (cycle > prog.size() - 1 + LATENCY && exp_idx == exp_wb.size()) begin
        drained = 1'b1;
      end
    end
  end

  initial begin : watchdog
    int wd_cycles;
    wd_cycles = 0;
    wait (running);
    while (wd_cycles < timeout_limit) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("Error: pipeline still running after %0d cycles", timeout_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    int load_cycles;
    int total;
    reset     = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    fill_tables();
    load_cycles   = (prog.size() > RESET_CYCLES) ? prog.size() : RESET_CYCLES;
    timeout_limit = prog.size() + LATENCY + MARGIN;

    // Program load while reset is held
    for (int i = 0; i < load_cycles; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      imem_we = (i < prog.size());
      if (i < prog.size()) begin
        imem_addr = IMEM_AW'(i);
        imem_data = prog[i];
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    imem_we = 1'b0;
    reset   = 1'b0;
    running = 1'b1; // Next edge is cycle 0

    wait (drained);
    total = mismatches + missing + extra + other_errors;
    $display("Summary: %0d write-backs checked, %0d mismatches, %0d missing, %0d extra, %0d other",
             checked, mismatches, missing, extra, other_errors);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+verif
source/mips_pkg.sv
source/pipe_reg.sv
source/if_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/mem_stage.sv
source/mips.sv
verif/tb_clock.sv
verif/tb_mips.sv
